// File: verilog/chipset_cfg.svh
`ifndef CHIPSET_CFG_SVH
`define CHIPSET_CFG_SVH

// Address map
`define RAM_BASE_NIBBLE 4'h1          // Top nibble of any RAM address
`define DSP_ADDR        32'hFF000000
`define SW_ADDR         32'hFF000004
`define KBD_ADDR        32'hFF000008
`define UART_ADDR       32'hFF000010

// System RAM size in 32-bit words
`define RAM_WORDS       256

// Entries per device queue
`define FIFO_DEPTH      4

// Clocks per UART bit
`define UART_DIVISOR    16

// Clocks per display digit, kept short for simulation
`define DSP_DIVISOR     8

`endif

// File: verilog/chipset_pkg.sv
package chipset_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // One data port request from the CPU
    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] wmask;   // One bit per byte lane
        logic       read;
    } bus_req_t;

    // One-hot device select
    typedef struct packed {
        logic ram;
        logic display;
        logic switches;
        logic keyboard;
        logic uart;
    } chip_select_t;

    // Key press or release
    typedef struct packed {
        logic  released;  // Code came after an F0 prefix
        byte_t code;
    } kbd_event_t;

endpackage

// File: verilog/event_fifo.sv
`timescale 1ns/10ps

module event_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     cpu_clk_i,
    input  logic     rst_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     valid_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr_r;
    logic [PTR_W-1:0] wr_ptr_r;
    logic [CNT_W-1:0] count_r;
    logic             do_pop_w;
    logic             do_push_w;

    assign valid_o   = (count_r != '0);
    assign data_o    = mem[rd_ptr_r];
    assign do_pop_w  = pop_i && valid_o;
    // Full queue drops unless a pop frees a slot this cycle
    assign do_push_w = push_i && ((count_r != CNT_W'(DEPTH)) || do_pop_w);

    always_ff @(posedge cpu_clk_i) begin
        if (do_push_w)
            mem[wr_ptr_r] <= data_i;
    end

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            rd_ptr_r <= '0;
            wr_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (do_push_w)
                wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
            if (do_pop_w)
                rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
            if (do_push_w && !do_pop_w)
                count_r <= count_r + 1'b1;
            else if (do_pop_w && !do_push_w)
                count_r <= count_r - 1'b1;
        end
    end

endmodule

// File: verilog/system_ram.sv
`timescale 1ns/10ps
`include "chipset_cfg.svh"

module system_ram
    import chipset_pkg::*;
(
    input  logic     cpu_clk_i,
    input  logic     cs_i,
    input  bus_req_t bus_req_i,
    output word_t    rdata_o
);

    word_t      mem [`RAM_WORDS];
    logic [7:0] index_w;

    assign index_w = bus_req_i.addr[9:2];  // Word index

    always_ff @(posedge cpu_clk_i) begin
        if (cs_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus_req_i.wmask[lane])
                    mem[index_w][lane*8 +: 8] <= bus_req_i.wdata[lane*8 +: 8];
            end
            rdata_o <= mem[index_w];  // Old word on a same-cycle write
        end
    end

endmodule

// File: verilog/seg_display.sv
`timescale 1ns/10ps
`include "chipset_cfg.svh"

module seg_display
    import chipset_pkg::*;
(
    input  logic       cpu_clk_i,
    input  logic       rst_i,
    input  logic       cs_i,
    input  bus_req_t   bus_req_i,
    output word_t      rdata_o,
    output logic [7:0] dsp_anode_o,
    output logic [7:0] dsp_cathode_o
);

    localparam int SCAN_W = $clog2(`DSP_DIVISOR);

    word_t             value_r;
    logic [SCAN_W-1:0] scan_cnt_r;
    logic [2:0]        digit_r;
    logic [3:0]        nibble_w;
    logic [6:0]        seg_w;     // Active low, g down to a

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            value_r <= '0;
        end else if (cs_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus_req_i.wmask[lane])
                    value_r[lane*8 +: 8] <= bus_req_i.wdata[lane*8 +: 8];
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        rdata_o <= value_r;
    end

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            scan_cnt_r <= '0;
            digit_r    <= '0;
        end else if (scan_cnt_r == SCAN_W'(`DSP_DIVISOR - 1)) begin
            scan_cnt_r <= '0;
            digit_r    <= digit_r + 3'd1;  // Next digit
        end else begin
            scan_cnt_r <= scan_cnt_r + 1'b1;
        end
    end

    assign nibble_w = value_r[digit_r*4 +: 4];

    always_comb begin
        case (nibble_w)
            4'h0: seg_w = 7'b1000000;
            4'h1: seg_w = 7'b1111001;
            4'h2: seg_w = 7'b0100100;
            4'h3: seg_w = 7'b0110000;
            4'h4: seg_w = 7'b0011001;
            4'h5: seg_w = 7'b0010010;
            4'h6: seg_w = 7'b0000010;
            4'h7: seg_w = 7'b1111000;
            4'h8: seg_w = 7'b0000000;
            4'h9: seg_w = 7'b0010000;
            4'hA: seg_w = 7'b0001000;
            4'hB: seg_w = 7'b0000011;
            4'hC: seg_w = 7'b1000110;
            4'hD: seg_w = 7'b0100001;
            4'hE: seg_w = 7'b0000110;
            default: seg_w = 7'b0001110;
        endcase
    end

    assign dsp_anode_o   = ~(8'b1 << digit_r);
    assign dsp_cathode_o = {1'b1, seg_w};  // Decimal point off

endmodule

// File: verilog/ps2_receiver.sv
`timescale 1ns/10ps

module ps2_receiver
    import chipset_pkg::*;
(
    input  logic       cpu_clk_i,
    input  logic       rst_i,
    input  logic       ps2_clk_i,
    input  logic       ps2_data_i,
    output kbd_event_t event_o,
    output logic       push_o
);

    logic [2:0]  clk_sync_r;    // Two sync stages plus previous value
    logic [1:0]  data_sync_r;
    logic        fall_w;
    logic [10:0] frame_r;       // Start, 8 data, parity, stop
    logic [3:0]  bit_cnt_r;
    logic        frame_done_r;
    logic        release_pending_r;
    logic        frame_ok_w;
    byte_t       code_w;

    assign fall_w = clk_sync_r[2] && !clk_sync_r[1];
    assign code_w = frame_r[8:1];

    // Start low, odd parity over data and parity, stop high
    assign frame_ok_w = !frame_r[0] && (^frame_r[9:1]) && frame_r[10];

    assign push_o  = frame_done_r && frame_ok_w && (code_w != 8'hF0);
    assign event_o = '{released: release_pending_r, code: code_w};

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            clk_sync_r  <= '1;
            data_sync_r <= '1;
        end else begin
            clk_sync_r  <= {clk_sync_r[1:0], ps2_clk_i};
            data_sync_r <= {data_sync_r[0], ps2_data_i};
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (fall_w)
            frame_r <= {data_sync_r[1], frame_r[10:1]};  // LSB arrives first
    end

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            bit_cnt_r         <= '0;
            frame_done_r      <= 1'b0;
            release_pending_r <= 1'b0;
        end else begin
            frame_done_r <= fall_w && (bit_cnt_r == 4'd10);
            if (fall_w)
                bit_cnt_r <= (bit_cnt_r == 4'd10) ? 4'd0 : bit_cnt_r + 4'd1;
            if (frame_done_r && frame_ok_w)
                release_pending_r <= (code_w == 8'hF0);  // Prefix arms, next code clears
        end
    end

endmodule

// File: verilog/uart_receiver.sv
`timescale 1ns/10ps
`include "chipset_cfg.svh"

module uart_receiver
    import chipset_pkg::*;
(
    input  logic  cpu_clk_i,
    input  logic  rst_i,
    input  logic  uart_rxd_i,
    output byte_t byte_o,
    output logic  push_o
);

    localparam int               CNT_W     = $clog2(`UART_DIVISOR);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_DIVISOR - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_DIVISOR / 2 - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t           state_r;
    logic [1:0]       rxd_sync_r;
    logic             rxd_w;
    logic [CNT_W-1:0] clk_cnt_r;
    logic [2:0]       bit_idx_r;
    byte_t            shift_r;

    assign rxd_w  = rxd_sync_r[1];
    assign byte_o = shift_r;

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i)
            rxd_sync_r <= 2'b11;  // Line idles high
        else
            rxd_sync_r <= {rxd_sync_r[0], uart_rxd_i};
    end

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            state_r   <= IDLE;
            clk_cnt_r <= '0;
            bit_idx_r <= '0;
            push_o    <= 1'b0;
        end else begin
            push_o <= 1'b0;
            case (state_r)
                IDLE: begin
                    clk_cnt_r <= '0;
                    if (!rxd_w)
                        state_r <= START;
                end
                START: begin
                    if (clk_cnt_r == HALF_LAST) begin
                        clk_cnt_r <= '0;
                        bit_idx_r <= '0;
                        state_r   <= rxd_w ? IDLE : DATA;  // Glitch returns to idle
                    end else begin
                        clk_cnt_r <= clk_cnt_r + 1'b1;
                    end
                end
                DATA: begin
                    if (clk_cnt_r == BIT_LAST) begin
                        clk_cnt_r <= '0;
                        shift_r   <= {rxd_w, shift_r[7:1]};
                        bit_idx_r <= bit_idx_r + 3'd1;
                        if (bit_idx_r == 3'd7)
                            state_r <= STOP;
                    end else begin
                        clk_cnt_r <= clk_cnt_r + 1'b1;
                    end
                end
                STOP: begin
                    if (clk_cnt_r == BIT_LAST) begin
                        push_o  <= rxd_w;  // Framing error drops the byte
                        state_r <= IDLE;
                    end else begin
                        clk_cnt_r <= clk_cnt_r + 1'b1;
                    end
                end
                default: state_r <= IDLE;
            endcase
        end
    end

endmodule

// File: verilog/bus_fabric.sv
`timescale 1ns/10ps
`include "chipset_cfg.svh"

module bus_fabric
    import chipset_pkg::*;
(
    input  logic         cpu_clk_i,
    input  logic         rst_i,
    input  bus_req_t     bus_req_i,
    input  logic [15:0]  switch_i,
    input  word_t        ram_rdata_i,
    input  word_t        dsp_rdata_i,
    input  kbd_event_t   kbd_event_i,
    input  logic         kbd_valid_i,
    input  byte_t        uart_byte_i,
    input  logic         uart_valid_i,
    output chip_select_t cs_o,
    output logic         kbd_pop_o,
    output logic         uart_pop_o,
    output word_t        rdata_o
);

    chip_select_t cs_r;           // Steers the mux one cycle later
    logic [15:0]  switch_meta_r;
    logic [15:0]  switch_sync_r;
    logic [15:0]  switch_r;
    word_t        kbd_word_r;     // Queue heads captured before the pop lands
    word_t        uart_word_r;

    always_comb begin
        if (bus_req_i.addr[31:28] == `RAM_BASE_NIBBLE)
            cs_o = '{ram: 1'b1, default: 1'b0};
        else if (bus_req_i.addr == `DSP_ADDR)
            cs_o = '{display: 1'b1, default: 1'b0};
        else if (bus_req_i.addr == `SW_ADDR)
            cs_o = '{switches: 1'b1, default: 1'b0};
        else if (bus_req_i.addr == `KBD_ADDR)
            cs_o = '{keyboard: 1'b1, default: 1'b0};
        else if (bus_req_i.addr == `UART_ADDR)
            cs_o = '{uart: 1'b1, default: 1'b0};
        else
            cs_o = '{default: 1'b0};
    end

    // A read of a queue address consumes its head
    assign kbd_pop_o  = cs_o.keyboard && bus_req_i.read && kbd_valid_i;
    assign uart_pop_o = cs_o.uart && bus_req_i.read && uart_valid_i;

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i)
            cs_r <= '0;
        else if (bus_req_i.read)
            cs_r <= cs_o;
        else
            cs_r <= '0;
    end

    always_ff @(posedge cpu_clk_i) begin
        switch_meta_r <= switch_i;
        switch_sync_r <= switch_meta_r;
        switch_r      <= switch_sync_r;
        // Empty queues read back as all zeros
        kbd_word_r    <= kbd_valid_i ? {15'b0, 1'b1, 7'b0, kbd_event_i} : '0;
        uart_word_r   <= uart_valid_i ? {23'b0, 1'b1, uart_byte_i} : '0;
    end

    always_comb begin
        if (cs_r.ram)
            rdata_o = ram_rdata_i;
        else if (cs_r.keyboard)
            rdata_o = kbd_word_r;
        else if (cs_r.display)
            rdata_o = dsp_rdata_i;
        else if (cs_r.switches)
            rdata_o = {16'b0, switch_r};
        else if (cs_r.uart)
            rdata_o = uart_word_r;
        else
            rdata_o = '0;                  // Unmapped or no read
    end

endmodule

// File: verilog/chipset.sv
`timescale 1ns/10ps
`include "chipset_cfg.svh"

module chipset
    import chipset_pkg::*;
(
    input  logic        cpu_clk_i,
    input  logic        rst_i,
    input  bus_req_t    bus_req_i,
    output word_t       rdata_o,
    output logic        interrupt_o,
    input  logic        ps2_clk_i,
    input  logic        ps2_data_i,
    input  logic        uart_rxd_i,
    input  logic [15:0] switch_i,
    output logic [7:0]  dsp_anode_o,
    output logic [7:0]  dsp_cathode_o
);

    chip_select_t cs_w;
    word_t        ram_rdata_w;
    word_t        dsp_rdata_w;

    kbd_event_t   kbd_push_event_w;
    logic         kbd_push_w;
    kbd_event_t   kbd_head_w;
    logic         kbd_valid_w;
    logic         kbd_pop_w;

    byte_t        uart_push_byte_w;
    logic         uart_push_w;
    byte_t        uart_head_w;
    logic         uart_valid_w;
    logic         uart_pop_w;

    assign interrupt_o = kbd_valid_w;  // Pending key events

    bus_fabric fabric (
        .cpu_clk_i   (cpu_clk_i),
        .rst_i       (rst_i),
        .bus_req_i   (bus_req_i),
        .switch_i    (switch_i),
        .ram_rdata_i (ram_rdata_w),
        .dsp_rdata_i (dsp_rdata_w),
        .kbd_event_i (kbd_head_w),
        .kbd_valid_i (kbd_valid_w),
        .uart_byte_i (uart_head_w),
        .uart_valid_i(uart_valid_w),
        .cs_o        (cs_w),
        .kbd_pop_o   (kbd_pop_w),
        .uart_pop_o  (uart_pop_w),
        .rdata_o     (rdata_o)
    );

    system_ram ram (
        .cpu_clk_i(cpu_clk_i),
        .cs_i     (cs_w.ram),
        .bus_req_i(bus_req_i),
        .rdata_o  (ram_rdata_w)
    );

    seg_display display (
        .cpu_clk_i    (cpu_clk_i),
        .rst_i        (rst_i),
        .cs_i         (cs_w.display),
        .bus_req_i    (bus_req_i),
        .rdata_o      (dsp_rdata_w),
        .dsp_anode_o  (dsp_anode_o),
        .dsp_cathode_o(dsp_cathode_o)
    );

    ps2_receiver ps2 (
        .cpu_clk_i (cpu_clk_i),
        .rst_i     (rst_i),
        .ps2_clk_i (ps2_clk_i),
        .ps2_data_i(ps2_data_i),
        .event_o   (kbd_push_event_w),
        .push_o    (kbd_push_w)
    );

    event_fifo #(.payload_t(kbd_event_t), .DEPTH(`FIFO_DEPTH)) kbd_fifo (
        .cpu_clk_i(cpu_clk_i),
        .rst_i    (rst_i),
        .push_i   (kbd_push_w),
        .data_i   (kbd_push_event_w),
        .pop_i    (kbd_pop_w),
        .data_o   (kbd_head_w),
        .valid_o  (kbd_valid_w)
    );

    uart_receiver uart_rx (
        .cpu_clk_i (cpu_clk_i),
        .rst_i     (rst_i),
        .uart_rxd_i(uart_rxd_i),
        .byte_o    (uart_push_byte_w),
        .push_o    (uart_push_w)
    );

    event_fifo #(.payload_t(byte_t), .DEPTH(`FIFO_DEPTH)) uart_fifo (
        .cpu_clk_i(cpu_clk_i),
        .rst_i    (rst_i),
        .push_i   (uart_push_w),
        .data_i   (uart_push_byte_w),
        .pop_i    (uart_pop_w),
        .data_o   (uart_head_w),
        .valid_o  (uart_valid_w)
    );

endmodule

// File: verification/chipset_checker.sv
`timescale 1ns/10ps

module chipset_checker
    import chipset_pkg::*;
(
    input logic         cpu_clk_i,
    input logic         rst_i,
    input logic [7:0]   dsp_anode_i,
    input logic         interrupt_i,
    input logic         kbd_valid_i,
    input chip_select_t cs_i
);

    // One digit lit at a time
    anode_one_low: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        $onehot(~dsp_anode_i))
        else $error("Display anodes do not select exactly one digit");

    irq_follows_queue: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        interrupt_i == kbd_valid_i)
        else $error("Interrupt differs from keyboard queue state");

    select_one_hot: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        $onehot0(cs_i))
        else $error("More than one chip select active");

endmodule

bind chipset chipset_checker checker_i (
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .dsp_anode_i(dsp_anode_o),
    .interrupt_i(interrupt_o),
    .kbd_valid_i(kbd_valid_w),
    .cs_i       (cs_w)
);

// File: verification/tb_chipset.sv
`timescale 1ns/10ps
`include "chipset_cfg.svh"

module tb_chipset
    import chipset_pkg::*;
();

    localparam int DIGIT_TIMEOUT = 200;  // Full scan of eight digits with margin
    localparam int PS2_HALF      = 4;    // CPU cycles per PS/2 clock phase

    logic        cpu_clk;
    logic        rst;
    bus_req_t    bus_req;
    word_t       rdata;
    logic        interrupt;
    logic        ps2_clk;
    logic        ps2_data;
    logic        uart_rxd;
    logic [15:0] switches;
    logic [7:0]  dsp_anode;
    logic [7:0]  dsp_cathode;

    int mismatches;
    int failures;   // Timeouts and trace file problems

    chipset dut (
        .cpu_clk_i    (cpu_clk),
        .rst_i        (rst),
        .bus_req_i    (bus_req),
        .rdata_o      (rdata),
        .interrupt_o  (interrupt),
        .ps2_clk_i    (ps2_clk),
        .ps2_data_i   (ps2_data),
        .uart_rxd_i   (uart_rxd),
        .switch_i     (switches),
        .dsp_anode_o  (dsp_anode),
        .dsp_cathode_o(dsp_cathode)
    );

    always #10 cpu_clk = ~cpu_clk;

    // Step n edges and land just after the last one
    task automatic tick(input int n);
        if (n > 0) begin
            repeat (n) @(posedge cpu_clk);
            #2;
        end
    endtask

    task automatic compare(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s gave %h, expected %h",
                     $time, what, got, expected);
            mismatches++;
        end
    endtask

    task automatic bus_write(input word_t address, input word_t data, input logic [3:0] mask);
        bus_req = '{addr: address, wdata: data, wmask: mask, read: 1'b0};
        tick(1);
        bus_req = '0;
    endtask

    task automatic bus_read(input word_t address, output word_t data);
        bus_req = '{addr: address, wdata: '0, wmask: 4'h0, read: 1'b1};
        tick(1);
        bus_req = '0;
        data = rdata;  // One cycle after the request edge
    endtask

    // Start, eight data bits LSB first, odd parity, stop
    task automatic send_ps2(input byte_t code);
        logic [10:0] frame;
        frame = {1'b1, ~^code, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            tick(PS2_HALF);
            ps2_clk = 1'b0;  // Receiver takes the bit here
            tick(PS2_HALF);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        tick(PS2_HALF);
    endtask

    task automatic send_uart(input byte_t data);
        uart_rxd = 1'b0;
        tick(`UART_DIVISOR);
        for (int i = 0; i < 8; i++) begin
            uart_rxd = data[i];
            tick(`UART_DIVISOR);
        end
        uart_rxd = 1'b1;
        tick(2 * `UART_DIVISOR);  // Stop bit plus time to queue
    endtask

    task automatic wait_digit(input logic [2:0] digit);
        int         waited;
        logic [7:0] expected;
        expected        = 8'hFF;
        expected[digit] = 1'b0;  // Active-low select
        waited = 0;
        while (dsp_anode !== expected && waited < DIGIT_TIMEOUT) begin
            tick(1);
            waited++;
        end
        if (dsp_anode !== expected) begin
            $display("Timeout at %0t ns waiting for digit %0d on the anodes", $time, digit);
            failures++;
        end
    endtask

    initial begin
        int    fd;
        string line;
        byte   cmd;
        word_t a_val;
        word_t b_val;
        word_t c_val;
        word_t got;
        bit    acted;

        cpu_clk    = 1'b0;
        rst        = 1'b1;
        bus_req    = '0;
        ps2_clk    = 1'b1;
        ps2_data   = 1'b1;
        uart_rxd   = 1'b1;
        switches   = '0;
        mismatches = 0;
        failures   = 0;
        void'($urandom(32'hed7b4759));
        tick(8);
        rst = 1'b0;

        // Idle outputs straight out of reset
        compare("interrupt after reset", {31'b0, interrupt}, '0);
        compare("anodes after reset", {24'b0, dsp_anode}, 32'h0000_00FE);
        compare("cathodes after reset", {24'b0, dsp_cathode}, 32'h0000_00C0);
        compare("rdata after reset", rdata, '0);

        fd = $fopen("verification/chipset_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/chipset_trace.txt");
            failures++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cmd  = 8'h00;
                void'($fgets(line, fd));
                void'($sscanf(line, "%c %h %h %h", cmd, a_val, b_val, c_val));
                acted = 1'b1;
                case (cmd)
                    "W": bus_write(a_val, b_val, c_val[3:0]);
                    "R": begin
                        if (a_val == `KBD_ADDR)  // Interrupt tracks queued key events
                            compare("interrupt", {31'b0, interrupt}, {31'b0, b_val[16]});
                        bus_read(a_val, got);
                        compare($sformatf("read of %h", a_val), got, b_val);
                    end
                    "K": send_ps2(a_val[7:0]);
                    "U": send_uart(a_val[7:0]);
                    "S": begin
                        switches = a_val[15:0];
                        tick(4);  // Two sync flops and the sample register
                    end
                    "D": begin
                        wait_digit(a_val[2:0]);
                        compare($sformatf("cathodes of digit %0d", a_val[2:0]),
                                {24'b0, dsp_cathode}, b_val);
                    end
                    default: acted = 1'b0;  // Comment or blank line
                endcase
                if (acted)
                    tick($urandom_range(3, 0));
            end
            $fclose(fd);
        end

        $display("Errors: %0d value mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: verification/chipset_trace.txt
# cmd then hex fields: W addr data mask | R addr expected | K scan code | U byte
# S switch value | D digit expected cathodes
W 10000010 11223344 f
W 10000010 aabbccdd 5
R 10000010 11bb33dd
R 20000000 00000000
W ff000000 12345678 f
W ff000000 aabbccdd 2
R ff000000 1234cc78
D 0 80
D 2 c6
D 5 b0
S a5c3
R ff000004 0000a5c3
K 1c
K f0
K 32
R ff000008 0001001c
R ff000008 00010132
K 15
K 16
K 1e
K 26
K 25
R ff000008 00010015
R ff000008 00010016
R ff000008 0001001e
R ff000008 00010026
R ff000008 00000000
U 41
U 5a
U 7e
R ff000010 00000141
R ff000010 0000015a
R ff000010 0000017e
R ff000010 00000000

// File: files.f
+incdir+verilog
verilog/chipset_pkg.sv
verilog/event_fifo.sv
verilog/system_ram.sv
verilog/seg_display.sv
verilog/ps2_receiver.sv
verilog/uart_receiver.sv
verilog/bus_fabric.sv
verilog/chipset.sv
verification/chipset_checker.sv
verification/tb_chipset.sv

// File: run_sim.sh
#!/bin/bash
# Build the chipset testbench with Verilator, run it and scan the log

set -o pipefail

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_chipset \
    -o tb_chipset_sim \
    && ./obj_dir/tb_chipset_sim 2>&1 | tee sim.log \
    && ! grep -q "Testbench failed" sim.log \
    && grep -q "Testbench passed" sim.log \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed, see sim.log"; exit 1; }
